/* tb.f */
+incdir+design
design/soc_pkg.sv
design/apb_decoder.sv
design/main_memory.sv
design/timer_unit.sv
design/plic.sv
design/soc_top.sv
testbench/tb_clock.sv
testbench/tb_top.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f tb.f --top-module tb_top -o sim_tb

output="$(./obj_dir/sim_tb)"
echo "$output"

if grep -qF "Finished with no errors" <<< "$output"; then
    exit 0
fi
exit 1

/* testbench/tb_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "soc_settings.svh"

module tb_top;

    localparam int AW             = `APB_ADDR_WIDTH;
    localparam int DW             = `APB_DATA_WIDTH;
    localparam int TIMEOUT_CYCLES = 4000; // all tests need well under 1000
    localparam int STRIDE         = `MEM_WORDS / 16; // one random word per slice

    //////////////////////////////////////////////////
    // address map
    //////////////////////////////////////////////////

    localparam logic [AW-1:0] TIMER_BASE     = AW'(32'h10000);
    localparam logic [AW-1:0] PLIC_BASE      = AW'(32'h20000);
    localparam logic [AW-1:0] NONE_BASE      = AW'(32'h30000); // hole
    localparam logic [AW-1:0] PLIC_ENABLE    = PLIC_BASE + AW'(32'h080);
    localparam logic [AW-1:0] PLIC_THRESHOLD = PLIC_BASE + AW'(32'h100);
    localparam logic [AW-1:0] PLIC_CLAIM     = PLIC_BASE + AW'(32'h104);

    // word index inside a timer window
    localparam int CTRL   = 0;
    localparam int LOAD   = 1;
    localparam int COUNT  = 2;
    localparam int STATUS = 3;

    logic          clk;
    logic          rst;
    logic          psel;
    logic          penable;
    logic          pwrite;
    logic [AW-1:0] paddr;
    logic [DW-1:0] pwdata;
    logic [DW-1:0] prdata;
    logic          pready;
    logic          pslverr;
    logic          irq;
    int            errors = 0;
    int            cycles = 0;

    tb_clock clock_u (
        .clk_o   ( clk ),
        .reset_o ( rst )
    );

    soc_top uut (
        .clk_i     ( clk     ),
        .reset_i   ( rst     ),
        .psel_i    ( psel    ),
        .penable_i ( penable ),
        .pwrite_i  ( pwrite  ),
        .paddr_i   ( paddr   ),
        .pwdata_i  ( pwdata  ),
        .prdata_o  ( prdata  ),
        .pready_o  ( pready  ),
        .pslverr_o ( pslverr ),
        .irq_o     ( irq     )
    );

    // watchdog
    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: run stopped after %0d clock cycles", cycles);
            $display("Finished with errors");
            $finish;
        end
    end

    function automatic logic [AW-1:0] timer_addr(input int n, input int r);
        return TIMER_BASE + AW'(n * 16 + r * 4);
    endfunction

    function automatic logic [AW-1:0] mem_addr(input int idx);
        return AW'(idx * 4);
    endfunction

    function automatic logic [AW-1:0] prio_addr(input int id);
        return PLIC_BASE + AW'(id * 4);
    endfunction

    task automatic check(input string name, input logic [DW-1:0] actual,
                         input logic [DW-1:0] expected);
        if (actual !== expected) begin
            $display("ERROR: %s got 0x%08h expected 0x%08h", name, actual, expected);
            errors++;
        end
    endtask

    //////////////////////////////////////////////////
    // apb driver
    //////////////////////////////////////////////////

    task automatic apb_transfer(input logic write, input logic [AW-1:0] addr,
                                input logic [DW-1:0] wdata, output logic [DW-1:0] rdata,
                                output logic err);
        @(posedge clk);
        #1;
        psel    = 1'b1; // setup
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1; // access
        #2; // let the combinational response settle
        check("pready_o", DW'(pready), 32'd1); // zero wait states
        rdata = prdata;
        err   = pslverr;
        @(posedge clk); // completing edge
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [AW-1:0] addr, input logic [DW-1:0] data);
        logic [DW-1:0] unused_rdata;
        logic          err;
        apb_transfer(1'b1, addr, data, unused_rdata, err);
        check("pslverr_o", DW'(err), '0);
    endtask

    task automatic apb_read(input logic [AW-1:0] addr, output logic [DW-1:0] data);
        logic err;
        apb_transfer(1'b0, addr, '0, data, err);
        check("pslverr_o", DW'(err), '0);
    endtask

    task automatic read_check(input string name, input logic [AW-1:0] addr,
                              input logic [DW-1:0] expected);
        logic [DW-1:0] data;
        apb_read(addr, data);
        check(name, data, expected);
    endtask

    // one status read per poll
    task automatic wait_expired(input int n, input int max_polls);
        logic [DW-1:0] status;
        logic          found;
        found = 1'b0;
        for (int p = 0; p < max_polls && !found; p++) begin
            apb_read(timer_addr(n, STATUS), status);
            found = status[0];
        end
        if (!found) begin
            $display("timer %0d did not expire within %0d status polls", n, max_polls);
            errors++;
        end
    endtask

    //////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////

    task automatic reset_state();
        check("irq_o", DW'(irq), '0);
        check("pready_o", DW'(pready), '0);
        check("pslverr_o", DW'(pslverr), '0);
        for (int n = 0; n < `NUM_TIMERS; n++) begin
            read_check($sformatf("timer%0d ctrl", n), timer_addr(n, CTRL), '0);
            read_check($sformatf("timer%0d status", n), timer_addr(n, STATUS), '0);
        end
        read_check("plic claim", PLIC_CLAIM, '0);
    endtask

    task automatic memory_readback();
        int            idx [16];
        logic [DW-1:0] exp_data [16];
        for (int i = 0; i < 16; i++) begin
            idx[i]      = i * STRIDE + int'($urandom % STRIDE); // distinct words
            exp_data[i] = $urandom;
            apb_write(mem_addr(idx[i]), exp_data[i]);
        end
        for (int i = 0; i < 16; i++) begin
            read_check($sformatf("mem[%0d]", idx[i]), mem_addr(idx[i]), exp_data[i]);
        end
    endtask

    task automatic unmapped_access();
        logic [DW-1:0] rdata;
        logic          err;
        apb_write(mem_addr(5), 32'hA5A5_0F0F);
        apb_transfer(1'b0, NONE_BASE, '0, rdata, err);
        check("pslverr_o", DW'(err), 32'd1);
        check("prdata_o", rdata, '0);
        apb_transfer(1'b1, NONE_BASE + AW'(20), 32'hDEAD_BEEF, rdata, err);
        check("pslverr_o", DW'(err), 32'd1);
        // past the end of memory the low bits alias word 5
        apb_transfer(1'b1, mem_addr(`MEM_WORDS + 5), 32'h1234_5678, rdata, err);
        check("pslverr_o", DW'(err), 32'd1);
        apb_transfer(1'b0, mem_addr(`MEM_WORDS + 5), '0, rdata, err);
        check("pslverr_o", DW'(err), 32'd1);
        check("prdata_o", rdata, '0);
        read_check("mem[5]", mem_addr(5), 32'hA5A5_0F0F);
    endtask

    task automatic one_shot_timer();
        apb_write(timer_addr(1, LOAD), 32'd20);
        apb_write(timer_addr(1, CTRL), 32'h1); // enable without reload
        wait_expired(1, 40);
        read_check("timer1 count", timer_addr(1, COUNT), '0);
        read_check("timer1 ctrl", timer_addr(1, CTRL), '0); // one-shot drops enable
        apb_write(timer_addr(1, STATUS), 32'h1);
        read_check("timer1 status", timer_addr(1, STATUS), '0);
    endtask

    task automatic plic_arbitration();
        apb_write(prio_addr(1), 32'd2); // timer 0
        apb_write(prio_addr(3), 32'd5); // timer 2
        apb_write(PLIC_ENABLE, 32'h0000_000A);
        apb_write(PLIC_THRESHOLD, '0);
        apb_write(timer_addr(0, LOAD), 32'd3);
        apb_write(timer_addr(2, LOAD), 32'd6);
        apb_write(timer_addr(0, CTRL), 32'h1);
        apb_write(timer_addr(2, CTRL), 32'h1);
        wait_expired(2, 40); // timer 0 is already done by now
        check("irq_o", DW'(irq), 32'd1);
        read_check("plic claim", PLIC_CLAIM, 32'd3); // higher priority wins
        apb_write(timer_addr(2, STATUS), 32'h1);
        apb_write(PLIC_CLAIM, 32'd3); // complete
        read_check("plic claim", PLIC_CLAIM, 32'd1);
        // completing id 1 re-arms it since its line is still high
        apb_write(PLIC_CLAIM, 32'd1);
        @(posedge clk);
        #1;
        check("irq_o", DW'(irq), 32'd1);
        apb_write(PLIC_THRESHOLD, 32'd5); // prio 2 no longer above threshold
        check("irq_o", DW'(irq), '0);
        read_check("plic claim", PLIC_CLAIM, '0);
        // quiet the plic again
        apb_write(timer_addr(0, STATUS), 32'h1);
        apb_write(PLIC_THRESHOLD, '0);
        apb_write(PLIC_ENABLE, '0);
    endtask

    task automatic auto_reload_timer();
        apb_write(timer_addr(3, LOAD), 32'd30); // long enough to clear between expiries
        apb_write(timer_addr(3, CTRL), 32'h3); // enable plus auto-reload
        wait_expired(3, 40);
        read_check("timer3 ctrl", timer_addr(3, CTRL), 32'h3);
        apb_write(timer_addr(3, STATUS), 32'h1);
        read_check("timer3 status", timer_addr(3, STATUS), '0);
        wait_expired(3, 40); // second period
        apb_write(timer_addr(3, CTRL), '0);
        apb_write(timer_addr(3, STATUS), 32'h1);
    endtask

    //////////////////////////////////////////////////
    // sequence
    //////////////////////////////////////////////////

    initial begin
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        void'($urandom(17));
        wait (rst === 1'b1);
        wait (rst === 1'b0);
        reset_state();
        memory_readback();
        unmapped_access();
        one_shot_timer();
        plic_arbitration();
        auto_reload_timer();
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule : tb_top

`default_nettype wire

/* testbench/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int HALF_PERIOD  = 5, // 10 ns period
    parameter int RESET_CYCLES = 2
) (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    // sync reset, dropped just after an edge
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1;
        reset_o = 1'b0;
    end

endmodule : tb_clock

`default_nettype wire

/* design/soc_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "soc_settings.svh"

module soc_top (
    input  wire                        clk_i,
    input  wire                        reset_i,
    // apb slave port, single external master
    input  wire                        psel_i,
    input  wire                        penable_i,
    input  wire                        pwrite_i,
    input  wire [`APB_ADDR_WIDTH-1:0]  paddr_i,
    input  wire [`APB_DATA_WIDTH-1:0]  pwdata_i,
    output logic [`APB_DATA_WIDTH-1:0] prdata_o,
    output logic                       pready_o,
    output logic                       pslverr_o,
    // external interrupt for the core
    output logic                       irq_o
);

    //////////////////////////////////////////////////
    // local signals
    //////////////////////////////////////////////////

    logic                       mem_psel;
    logic [`APB_DATA_WIDTH-1:0] mem_prdata;
    logic                       mem_pready;
    logic [`NUM_TIMERS-1:0]     timer_psel;
    logic [`APB_DATA_WIDTH-1:0] timer_prdata [`NUM_TIMERS];
    logic [`NUM_TIMERS-1:0]     timer_pready;
    logic [`NUM_TIMERS-1:0]     timer_irq; // timer n -> plic id n+1
    logic                       plic_psel;
    logic [`APB_DATA_WIDTH-1:0] plic_prdata;
    logic                       plic_pready;

    // address decode and response merge
    apb_decoder apb_decoder_u (
        .psel_i         ( psel_i       ),
        .penable_i      ( penable_i    ),
        .paddr_i        ( paddr_i      ),
        .mem_prdata_i   ( mem_prdata   ),
        .mem_pready_i   ( mem_pready   ),
        .timer_prdata_i ( timer_prdata ),
        .timer_pready_i ( timer_pready ),
        .plic_prdata_i  ( plic_prdata  ),
        .plic_pready_i  ( plic_pready  ),
        .mem_psel_o     ( mem_psel     ),
        .timer_psel_o   ( timer_psel   ),
        .plic_psel_o    ( plic_psel    ),
        .prdata_o       ( prdata_o     ),
        .pready_o       ( pready_o     ),
        .pslverr_o      ( pslverr_o    )
    );

    main_memory main_memory_u (
        .clk_i     ( clk_i      ),
        .reset_i   ( reset_i    ),
        .psel_i    ( mem_psel   ),
        .penable_i ( penable_i  ), // shared
        .pwrite_i  ( pwrite_i   ), // shared
        .paddr_i   ( paddr_i    ),
        .pwdata_i  ( pwdata_i   ),
        .prdata_o  ( mem_prdata ),
        .pready_o  ( mem_pready )
    );

    // peripheral timers
    for (genvar i = 0; i < `NUM_TIMERS; i++) begin : gen_timers
        timer_unit timer_unit_u (
            .clk_i     ( clk_i           ),
            .reset_i   ( reset_i         ),
            .psel_i    ( timer_psel[i]   ),
            .penable_i ( penable_i       ),
            .pwrite_i  ( pwrite_i        ),
            .paddr_i   ( paddr_i         ),
            .pwdata_i  ( pwdata_i        ),
            .prdata_o  ( timer_prdata[i] ),
            .pready_o  ( timer_pready[i] ),
            .irq_o     ( timer_irq[i]    )
        );
    end

    plic plic_u (
        .clk_i     ( clk_i       ),
        .reset_i   ( reset_i     ),
        .psel_i    ( plic_psel   ),
        .penable_i ( penable_i   ),
        .pwrite_i  ( pwrite_i    ),
        .paddr_i   ( paddr_i     ),
        .pwdata_i  ( pwdata_i    ),
        .src_i     ( timer_irq   ),
        .prdata_o  ( plic_prdata ),
        .pready_o  ( plic_pready ),
        .irq_o     ( irq_o       ) // merged external interrupt
    );

endmodule : soc_top

`default_nettype wire

/* design/plic.sv */
`timescale 1ns/1ps
`default_nettype none

`include "soc_settings.svh"

module plic import soc_pkg::*; (
    input  wire                        clk_i,
    input  wire                        reset_i,
    input  wire                        psel_i,
    input  wire                        penable_i,
    input  wire                        pwrite_i,
    input  wire [`APB_ADDR_WIDTH-1:0]  paddr_i,
    input  wire [`APB_DATA_WIDTH-1:0]  pwdata_i,
    input  wire [`NUM_TIMERS-1:0]      src_i, // src_i[n] is source id n+1
    output logic [`APB_DATA_WIDTH-1:0] prdata_o,
    output logic                       pready_o,
    output logic                       irq_o
);

    localparam int N  = `NUM_TIMERS;
    localparam int PW = `PLIC_PRIO_WIDTH;
    localparam int IW = `PLIC_ID_WIDTH;

    logic [PW-1:0] prio_q [N];
    logic [N-1:0]  enable_q;
    logic [N-1:0]  pending_q;
    logic [N-1:0]  in_service_q; // claimed, not yet completed
    logic [PW-1:0] threshold_q;
    plic_reg_e     reg_sel;
    logic [IW-1:0] addr_id; // source id of a prio access
    logic [IW-1:0] best_id;
    logic [PW-1:0] best_prio;
    logic          access;
    logic          wr_en;
    logic          claim_rd;
    logic          complete_wr;

    // group from offset bits 8:7, bit 2 splits threshold from claim
    always_comb begin
        case (paddr_i[8:7])
            2'd0:    reg_sel = PLIC_PRIO;
            2'd1:    reg_sel = PLIC_ENABLE;
            default: reg_sel = paddr_i[2] ? PLIC_CLAIM : PLIC_THRESHOLD;
        endcase
    end

    assign addr_id     = paddr_i[2 +: IW];
    assign access      = psel_i && penable_i && pready_o;
    assign wr_en       = access && pwrite_i;
    assign claim_rd    = access && !pwrite_i && (reg_sel == PLIC_CLAIM);
    assign complete_wr = wr_en && (reg_sel == PLIC_CLAIM);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pready_o <= 1'b0;
        end else begin
            pready_o <= psel_i && !penable_i;
        end
    end

    //////////////////////////////////////////////////
    // arbitration
    //////////////////////////////////////////////////

    // strict compare, so the lowest id keeps a tie
    always_comb begin
        best_id   = '0;
        best_prio = threshold_q; // must beat the threshold
        for (int i = 0; i < N; i++) begin
            if (pending_q[i] && enable_q[i] && (prio_q[i] > best_prio)) begin
                best_id   = IW'(i + 1);
                best_prio = prio_q[i];
            end
        end
    end

    assign irq_o = (best_id != '0);

    //////////////////////////////////////////////////
    // gateways and config registers
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < N; i++) begin
                prio_q[i] <= '0;
            end
            enable_q     <= '0;
            pending_q    <= '0;
            in_service_q <= '0;
            threshold_q  <= '0;
        end else begin
            for (int i = 0; i < N; i++) begin
                if (claim_rd && (best_id == IW'(i + 1))) begin
                    pending_q[i]    <= 1'b0;
                    in_service_q[i] <= 1'b1;
                end else begin
                    if (src_i[i] && !in_service_q[i]) begin
                        pending_q[i] <= 1'b1; // level gateway
                    end
                    if (complete_wr && (pwdata_i[IW-1:0] == IW'(i + 1))) begin
                        in_service_q[i] <= 1'b0;
                    end
                end
                if (wr_en && (reg_sel == PLIC_PRIO) && (addr_id == IW'(i + 1))) begin
                    prio_q[i] <= pwdata_i[PW-1:0];
                end
            end
            if (wr_en && (reg_sel == PLIC_ENABLE)) begin
                enable_q <= pwdata_i[N:1]; // bit 0 is reserved source
            end
            if (wr_en && (reg_sel == PLIC_THRESHOLD)) begin
                threshold_q <= pwdata_i[PW-1:0];
            end
        end
    end

    always_comb begin
        prdata_o = '0;
        case (reg_sel)
            PLIC_PRIO: begin
                for (int i = 0; i < N; i++) begin
                    if (addr_id == IW'(i + 1)) begin
                        prdata_o[PW-1:0] = prio_q[i];
                    end
                end
            end
            PLIC_ENABLE:    prdata_o[N:0]    = {enable_q, 1'b0};
            PLIC_THRESHOLD: prdata_o[PW-1:0] = threshold_q;
            PLIC_CLAIM:     prdata_o[IW-1:0] = best_id; // 0 means nothing to claim
            default: ;
        endcase
    end

endmodule : plic

`default_nettype wire

/* design/timer_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "soc_settings.svh"

module timer_unit import soc_pkg::*; (
    input  wire                        clk_i,
    input  wire                        reset_i,
    input  wire                        psel_i,
    input  wire                        penable_i,
    input  wire                        pwrite_i,
    input  wire [`APB_ADDR_WIDTH-1:0]  paddr_i,
    input  wire [`APB_DATA_WIDTH-1:0]  pwdata_i,
    output logic [`APB_DATA_WIDTH-1:0] prdata_o,
    output logic                       pready_o,
    output logic                       irq_o
);

    timer_reg_e                 reg_sel;
    logic                       enable_q; // ctrl bit 0
    logic                       reload_q; // ctrl bit 1
    logic                       expired_q; // status bit 0
    logic [`APB_DATA_WIDTH-1:0] load_q;
    logic [`APB_DATA_WIDTH-1:0] count_q;
    logic                       wr_en;
    logic                       expire_evt;

    assign reg_sel    = timer_reg_e'(paddr_i[3:2]);
    assign wr_en      = psel_i && penable_i && pwrite_i && pready_o;
    assign expire_evt = enable_q && (count_q == '0);

    // one access cycle, never stalls
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pready_o <= 1'b0;
        end else begin
            pready_o <= psel_i && !penable_i;
        end
    end

    //////////////////////////////////////////////////
    // counter and register file
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            enable_q  <= 1'b0;
            reload_q  <= 1'b0;
            expired_q <= 1'b0;
            load_q    <= '0;
            count_q   <= '0;
        end else begin
            if (expire_evt) begin
                expired_q <= 1'b1;
                if (reload_q) begin
                    count_q <= load_q; // periodic mode
                end else begin
                    enable_q <= 1'b0; // one-shot stops at zero
                end
            end else if (enable_q) begin
                count_q <= count_q - 1'b1;
            end
            // bus writes override the counter in the same cycle
            if (wr_en) begin
                case (reg_sel)
                    TIMER_CTRL: begin
                        enable_q <= pwdata_i[0];
                        reload_q <= pwdata_i[1];
                    end
                    TIMER_LOAD: begin
                        load_q  <= pwdata_i;
                        count_q <= pwdata_i;
                    end
                    TIMER_STATUS: begin
                        // a fresh expiry beats the clear
                        if (pwdata_i[0] && !expire_evt) begin
                            expired_q <= 1'b0;
                        end
                    end
                    default: ; // count is read only
                endcase
            end
        end
    end

    always_comb begin
        prdata_o = '0;
        case (reg_sel)
            TIMER_CTRL:   prdata_o[1:0] = {reload_q, enable_q};
            TIMER_LOAD:   prdata_o      = load_q;
            TIMER_COUNT:  prdata_o      = count_q;
            TIMER_STATUS: prdata_o[0]   = expired_q;
            default: ;
        endcase
    end

    assign irq_o = expired_q; // level, held until w1c

endmodule : timer_unit

`default_nettype wire

/* design/main_memory.sv */
`timescale 1ns/1ps
`default_nettype none

`include "soc_settings.svh"

module main_memory (
    input  wire                        clk_i,
    input  wire                        reset_i,
    input  wire                        psel_i,
    input  wire                        penable_i,
    input  wire                        pwrite_i,
    input  wire [`APB_ADDR_WIDTH-1:0]  paddr_i,
    input  wire [`APB_DATA_WIDTH-1:0]  pwdata_i,
    output logic [`APB_DATA_WIDTH-1:0] prdata_o,
    output logic                       pready_o
);

    localparam int IDX_W = $clog2(`MEM_WORDS);

    logic [`APB_DATA_WIDTH-1:0] mem_q [`MEM_WORDS]; // storage, no reset
    logic [IDX_W-1:0]           word_idx;
    logic                       wr_en;

    assign word_idx = paddr_i[IDX_W+1:2]; // drop byte offset
    assign wr_en    = psel_i && penable_i && pwrite_i && pready_o; // completing edge

    //////////////////////////////////////////////////
    // zero wait state handshake
    //////////////////////////////////////////////////

    // ready rises in the access cycle right after setup
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pready_o <= 1'b0;
        end else begin
            pready_o <= psel_i && !penable_i;
        end
    end

    //////////////////////////////////////////////////
    // array
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            mem_q[word_idx] <= pwdata_i;
        end
    end

    assign prdata_o = mem_q[word_idx]; // async read, valid in access cycle

endmodule : main_memory

`default_nettype wire

/* design/apb_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "soc_settings.svh"

module apb_decoder import soc_pkg::*; (
    input  wire                        psel_i,
    input  wire                        penable_i,
    input  wire [`APB_ADDR_WIDTH-1:0]  paddr_i,
    // slave responses
    input  wire [`APB_DATA_WIDTH-1:0]  mem_prdata_i,
    input  wire                        mem_pready_i,
    input  wire [`APB_DATA_WIDTH-1:0]  timer_prdata_i [`NUM_TIMERS],
    input  wire [`NUM_TIMERS-1:0]      timer_pready_i,
    input  wire [`APB_DATA_WIDTH-1:0]  plic_prdata_i,
    input  wire                        plic_pready_i,
    // selects
    output logic                       mem_psel_o,
    output logic [`NUM_TIMERS-1:0]     timer_psel_o,
    output logic                       plic_psel_o,
    // merged response to the master
    output logic [`APB_DATA_WIDTH-1:0] prdata_o,
    output logic                       pready_o,
    output logic                       pslverr_o
);

    localparam int TSEL_W     = $clog2(`NUM_TIMERS);
    localparam int MEM_BYTE_W = $clog2(`MEM_WORDS) + 2; // bytes covered by memory

    region_e           region;
    logic [TSEL_W-1:0] timer_idx;
    logic              mem_in_range;
    logic              unmapped;

    assign region       = region_e'(paddr_i[`REGION_LSB +: $bits(region_e)]);
    assign timer_idx    = paddr_i[`TIMER_SEL_LSB +: TSEL_W];
    assign mem_in_range = (paddr_i[`REGION_LSB-1:MEM_BYTE_W] == '0); // no aliasing
    assign unmapped     = (region == REGION_NONE) || (region == REGION_MEM && !mem_in_range);

    //////////////////////////////////////////////////
    // one-hot selects
    //////////////////////////////////////////////////

    always_comb begin
        mem_psel_o  = psel_i && (region == REGION_MEM) && mem_in_range;
        plic_psel_o = psel_i && (region == REGION_PLIC);
        for (int i = 0; i < `NUM_TIMERS; i++) begin
            timer_psel_o[i] = psel_i && (region == REGION_TIMER) && (timer_idx == TSEL_W'(i));
        end
    end

    //////////////////////////////////////////////////
    // response mux
    //////////////////////////////////////////////////

    always_comb begin
        prdata_o = '0; // unmapped reads return zero
        pready_o = psel_i && penable_i; // decoder answers for holes itself
        case (region)
            REGION_MEM: begin
                if (mem_in_range) begin
                    prdata_o = mem_prdata_i;
                    pready_o = mem_pready_i;
                end
            end
            REGION_TIMER: begin
                prdata_o = timer_prdata_i[timer_idx];
                pready_o = timer_pready_i[timer_idx];
            end
            REGION_PLIC: begin
                prdata_o = plic_prdata_i;
                pready_o = plic_pready_i;
            end
            default: ; // keep the error defaults
        endcase
    end

    // error only flagged in the access phase
    assign pslverr_o = psel_i && penable_i && unmapped;

endmodule : apb_decoder

`default_nettype wire

/* design/soc_pkg.sv */
`default_nettype none

package soc_pkg;

    // top address bits, one value per slave kind
    typedef enum logic [1:0] {
        REGION_MEM   = 2'd0, // base 0x00000
        REGION_TIMER = 2'd1, // base 0x10000
        REGION_PLIC  = 2'd2, // base 0x20000
        REGION_NONE  = 2'd3 // nothing here, error response
    } region_e;

    // word index inside one timer window
    typedef enum logic [1:0] {
        TIMER_CTRL   = 2'd0, // bit 0 enable, bit 1 auto-reload
        TIMER_LOAD   = 2'd1, // reload value, write also loads count
        TIMER_COUNT  = 2'd2, // read only
        TIMER_STATUS = 2'd3 // bit 0 expired, w1c
    } timer_reg_e;

    // plic register groups
    typedef enum logic [1:0] {
        PLIC_PRIO      = 2'd0, // 0x000 + 4*id
        PLIC_ENABLE    = 2'd1, // 0x080
        PLIC_THRESHOLD = 2'd2, // 0x100
        PLIC_CLAIM     = 2'd3 // 0x104, read claims, write completes
    } plic_reg_e;

endpackage : soc_pkg

`default_nettype wire

/* design/soc_settings.svh */
`ifndef SOC_SETTINGS_SVH
`define SOC_SETTINGS_SVH

//////////////////////////////////////////////////
// apb bus
//////////////////////////////////////////////////

`define APB_ADDR_WIDTH 18 // byte address, 256 KB window
`define APB_DATA_WIDTH 32

//////////////////////////////////////////////////
// slaves
//////////////////////////////////////////////////

`define MEM_WORDS 256 // main memory depth in words
`define NUM_TIMERS 4 // one plic source each

// plic field widths
`define PLIC_PRIO_WIDTH 3 // also the threshold width
`define PLIC_ID_WIDTH 3 // id 0 is reserved

//////////////////////////////////////////////////
// address map
//////////////////////////////////////////////////

// region field is paddr[17:16]
`define REGION_LSB 16
// timer index is paddr[5:4], 16-byte window per timer
`define TIMER_SEL_LSB 4

`endif
